/* rtl/radio_pkg.sv */
/*
 * Radio control core definitions
 * Settings bus addresses, word types and the readback slot encoding
 */
package radio_pkg;

   ////////////////////////////////////////
   // Word types
   ////////////////////////////////////////
   typedef logic [7:0]  set_addr_t;    // Settings bus address
   typedef logic [31:0] set_data_t;    // Settings bus data
   typedef logic [31:0] sample_t;      // I in [31:16], Q in [15:0]
   typedef logic [63:0] vita_time_t;   // Sample ticks
   typedef logic [63:0] rb_data_t;

   // Readback slots
   // Codes 4 to 7 have no source and read zero
   typedef enum logic [2:0] {
      RB_TEST     = 3'd0,
      RB_TIME     = 3'd1,
      RB_TIME_PPS = 3'd2,
      RB_TXRX     = 3'd3
   } rb_sel_t;

   ////////////////////////////////////////
   // Setting addresses
   ////////////////////////////////////////
   localparam set_addr_t SR_LOOPBACK   = 8'd6;
   localparam set_addr_t SR_TEST       = 8'd21;
   localparam set_addr_t SR_CODEC_IDLE = 8'd22;
   localparam set_addr_t SR_READBACK   = 8'd32;
   localparam set_addr_t SR_TX_CTRL    = 8'd64;    // Bit 0 runs TX

   // Time block occupies three addresses
   // High word, low word, then control
   localparam set_addr_t SR_TIME       = 8'd128;

   localparam set_addr_t SR_CNTRL      = 8'd163;   // Bit 0 clears codeword sequencer
   localparam set_addr_t SR_LLR_REG0   = 8'd164;   // Codeword 0
   localparam set_addr_t SR_LLR_REG1   = 8'd165;   // Codeword 1

   // Bit positions in the time control word
   localparam int TIME_CTRL_NOW = 0;
   localparam int TIME_CTRL_PPS = 1;

endpackage

/* rtl/radio_settings.sv */
/*
 * Radio settings registers
 * Decodes the settings bus strobe into one register per setting address
 */
`timescale 1ns/1ns

module radio_settings import radio_pkg::*; #(
   parameter sample_t TX_IDLE_RESET = '0     // Idle word out of reset
) (
   input  logic      bus_clk,
   input  logic      i_rst_n,

   // Settings bus
   input  logic      i_set_stb,
   input  set_addr_t i_set_addr,
   input  set_data_t i_set_data,

   // Register outputs
   output logic      o_loopback,
   output set_data_t o_test_word,
   output rb_sel_t   o_rb_sel,
   output sample_t   o_tx_idle,
   output sample_t   o_codeword0,
   output sample_t   o_codeword1,
   output logic      o_run_tx,
   output logic      o_seq_clear
);

   ////////////////////////////////////////
   // Register bank
   ////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_loopback  <= 1'b0;
         o_test_word <= '0;
         o_rb_sel    <= RB_TEST;
         o_tx_idle   <= TX_IDLE_RESET;
         o_codeword0 <= '0;
         o_codeword1 <= '0;
         o_run_tx    <= 1'b0;
         o_seq_clear <= 1'b0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_LOOPBACK: begin
               o_loopback <= i_set_data[0];   // TX looped onto RX
            end
            SR_TEST: begin
               o_test_word <= i_set_data;
            end
            SR_READBACK: begin
               // Unused codes are kept and read zero downstream
               o_rb_sel <= rb_sel_t'(i_set_data[2:0]);
            end
            SR_CODEC_IDLE: begin
               o_tx_idle <= i_set_data;
            end
            SR_LLR_REG0: begin
               o_codeword0 <= i_set_data;
            end
            SR_LLR_REG1: begin
               o_codeword1 <= i_set_data;
            end
            SR_TX_CTRL: begin
               o_run_tx <= i_set_data[0];
            end
            SR_CNTRL: begin
               o_seq_clear <= i_set_data[0];  // Level, held until rewritten
            end
            default: begin
               // Address belongs to another block
            end
         endcase
      end
   end

endmodule

/* rtl/time_keeper.sv */
/*
 * VITA timekeeper
 * 64-bit sample counter, loaded at once or on the next PPS rising edge,
 * with a copy of the count latched at every PPS edge
 */
`timescale 1ns/1ns

module time_keeper import radio_pkg::*; (
   input  logic       bus_clk,
   input  logic       i_rst_n,
   input  logic       i_set_stb,
   input  set_addr_t  i_set_addr,
   input  set_data_t  i_set_data,
   input  logic       i_pps,
   output vita_time_t o_vita_time,
   output vita_time_t o_vita_time_pps
);

   localparam set_addr_t SR_TIME_HI   = SR_TIME;
   localparam set_addr_t SR_TIME_LO   = SR_TIME + 8'd1;
   localparam set_addr_t SR_TIME_CTRL = SR_TIME + 8'd2;

   set_data_t time_hi;
   set_data_t time_lo;
   logic      pps_d;
   logic      pps_edge;
   logic      pps_armed;
   logic      ctrl_wr;

   assign pps_edge = i_pps & ~pps_d;   // First cycle of PPS high
   assign ctrl_wr  = i_set_stb && (i_set_addr == SR_TIME_CTRL);

   // Staging words and PPS arm
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         time_hi   <= '0;
         time_lo   <= '0;
         pps_d     <= 1'b0;
         pps_armed <= 1'b0;
      end else begin
         pps_d <= i_pps;
         if (i_set_stb && (i_set_addr == SR_TIME_HI))
            time_hi <= i_set_data;
         if (i_set_stb && (i_set_addr == SR_TIME_LO))
            time_lo <= i_set_data;
         if (ctrl_wr && i_set_data[TIME_CTRL_PPS])
            pps_armed <= 1'b1;
         else if (pps_edge)
            pps_armed <= 1'b0;             // One load per arm
      end
   end

   // Counter and last-PPS latch
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
      end else begin
         if (ctrl_wr && i_set_data[TIME_CTRL_NOW])
            o_vita_time <= {time_hi, time_lo};
         else if (pps_edge && pps_armed)
            o_vita_time <= {time_hi, time_lo};
         else
            o_vita_time <= o_vita_time + 64'd1;
         if (pps_edge)
            o_vita_time_pps <= o_vita_time;
      end
   end

endmodule

/* rtl/codeword_tx.sv */
/*
 * TX codeword source
 * Alternates codeword 0 and codeword 1 while running, idle word otherwise
 */
`timescale 1ns/1ns

module codeword_tx import radio_pkg::*; (
   input  logic    bus_clk,
   input  logic    i_rst_n,
   input  logic    i_run,
   input  logic    i_seq_clear,
   input  sample_t i_codeword0,
   input  sample_t i_codeword1,
   input  sample_t i_tx_idle,
   output sample_t o_tx
);

   logic    phase;      // 0 picks codeword 0
   logic    sel;
   sample_t codeword;

   // Clear wins over the stored phase so the next word is codeword 0
   assign sel      = phase & ~i_seq_clear;
   assign codeword = sel ? i_codeword1 : i_codeword0;

   ////////////////////////////////////////
   // Sequencer and output register
   ////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase <= 1'b0;
         o_tx  <= '0;
      end else begin
         if (i_run && !i_seq_clear)
            phase <= ~phase;
         else
            phase <= 1'b0;   // Restart at codeword 0

         o_tx <= i_run ? codeword : i_tx_idle;
      end
   end

endmodule

/* rtl/radio_readback.sv */
/*
 * Radio readback
 * Loopback RX select and the registered 64-bit readback mux
 */
`timescale 1ns/1ns

module radio_readback import radio_pkg::*; (
   input  logic       bus_clk,
   input  logic       i_rst_n,
   input  rb_sel_t    i_rb_sel,
   input  logic       i_loopback,
   input  sample_t    i_rx,
   input  sample_t    i_tx,
   input  set_data_t  i_test_word,
   input  vita_time_t i_vita_time,
   input  vita_time_t i_vita_time_pps,
   output rb_data_t   o_rb_data
);

   sample_t rx_word;

   // Digital loopback of TX onto RX
   assign rx_word = i_loopback ? i_tx : i_rx;

   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rb_data <= '0;
      end else begin
         case (i_rb_sel)
            RB_TEST:     o_rb_data <= {32'd0, i_test_word};
            RB_TIME:     o_rb_data <= i_vita_time;
            RB_TIME_PPS: o_rb_data <= i_vita_time_pps;   // Last PPS
            RB_TXRX:     o_rb_data <= {i_tx, rx_word};
            default:     o_rb_data <= '0;
         endcase
      end
   end

endmodule

/* rtl/radio_core.sv */
/*
 * Radio control core top level
 * Settings registers, VITA timekeeper, TX codeword source and readback
 */
`timescale 1ns/1ns

module radio_core import radio_pkg::*; #(
   parameter sample_t TX_IDLE_RESET = '0
) (
   input  logic       bus_clk,
   input  logic       i_rst_n,
   input  logic       i_set_stb,
   input  set_addr_t  i_set_addr,
   input  set_data_t  i_set_data,
   input  sample_t    i_rx,
   input  logic       i_pps,
   output sample_t    o_tx,
   output rb_data_t   o_rb_data,
   output vita_time_t o_vita_time
);

   logic       loopback;
   set_data_t  test_word;
   rb_sel_t    rb_sel;
   sample_t    tx_idle;
   sample_t    codeword0;
   sample_t    codeword1;
   logic       run_tx;
   logic       seq_clear;
   sample_t    tx_word;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   assign o_tx        = tx_word;
   assign o_vita_time = vita_time;

   ////////////////////////////////////////
   // Settings and time
   ////////////////////////////////////////
   radio_settings #(.TX_IDLE_RESET(TX_IDLE_RESET)) u_settings (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_loopback(loopback), .o_test_word(test_word), .o_rb_sel(rb_sel),
      .o_tx_idle(tx_idle), .o_codeword0(codeword0), .o_codeword1(codeword1),
      .o_run_tx(run_tx), .o_seq_clear(seq_clear));

   time_keeper u_time_keeper (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_pps(i_pps),
      .o_vita_time(vita_time), .o_vita_time_pps(vita_time_pps));

   ////////////////////////////////////////
   // TX source and readback
   ////////////////////////////////////////
   codeword_tx u_codeword_tx (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_run(run_tx), .i_seq_clear(seq_clear),
      .i_codeword0(codeword0), .i_codeword1(codeword1), .i_tx_idle(tx_idle),
      .o_tx(tx_word));

   radio_readback u_readback (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_rb_sel(rb_sel), .i_loopback(loopback),
      .i_rx(i_rx), .i_tx(tx_word), .i_test_word(test_word),
      .i_vita_time(vita_time), .i_vita_time_pps(vita_time_pps),
      .o_rb_data(o_rb_data));

endmodule

/* testbench/radio_core_asserts.sv */
/*
 * Radio core assertions
 * Time counting, idle TX word and unused readback slots
 */
`timescale 1ns/1ns

module radio_core_asserts import radio_pkg::*; (
   input logic       bus_clk,
   input logic       i_rst_n,
   input logic       i_set_stb,
   input set_addr_t  i_set_addr,
   input set_data_t  i_set_data,
   input logic       i_pps,
   input vita_time_t i_vita_time,
   input logic       i_run_tx,
   input sample_t    i_tx_idle,
   input sample_t    i_tx,
   input rb_sel_t    i_rb_sel,
   input rb_data_t   i_rb_data
);

   int   fail_count = 0;   // Failed assertions
   logic now_wr;

   assign now_wr = i_set_stb && (i_set_addr == SR_TIME + 8'd2) && i_set_data[TIME_CTRL_NOW];

   // Any PPS rise is excluded, armed or not
   time_counts: assert property (@(posedge bus_clk) disable iff (!i_rst_n)
      !now_wr && !$rose(i_pps) |=> i_vita_time == $past(i_vita_time) + 64'd1)
      else begin
         fail_count++;
         $error("VITA time did not advance by one");
      end

   tx_idles: assert property (@(posedge bus_clk) disable iff (!i_rst_n)
      !i_run_tx |=> i_tx == $past(i_tx_idle))
      else begin
         fail_count++;
         $error("TX word is not the idle word while stopped");
      end

   // Codes 4 to 7
   rb_unused_zero: assert property (@(posedge bus_clk) disable iff (!i_rst_n)
      i_rb_sel[2] |=> i_rb_data == '0)
      else begin
         fail_count++;
         $error("Unused readback slot is not zero");
      end

endmodule

bind radio_core radio_core_asserts u_asserts (
   .bus_clk(bus_clk), .i_rst_n(i_rst_n),
   .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
   .i_pps(i_pps), .i_vita_time(o_vita_time),
   .i_run_tx(run_tx), .i_tx_idle(tx_idle), .i_tx(o_tx),
   .i_rb_sel(rb_sel), .i_rb_data(o_rb_data));

/* testbench/radio_core_tb.sv */
/*
 * Radio control core testbench
 * Directed tests of settings, VITA time, PPS load, codewords and loopback
 */
`timescale 1ns/1ns

module radio_core_tb import radio_pkg::*; ();

   localparam sample_t IDLE_RESET = 32'h1357_9bdf;
   localparam int CLK_NS = 10;
   localparam int TEST_CYCLES = 4 + 1 + 5 + 13 + 13 + 19 + 7;   // Reset, then each test
   localparam int WATCHDOG_NS = (TEST_CYCLES + 20) * CLK_NS;

   logic       bus_clk;
   logic       i_rst_n;
   logic       i_set_stb;
   set_addr_t  i_set_addr;
   set_data_t  i_set_data;
   sample_t    i_rx;
   logic       i_pps;
   sample_t    o_tx;
   rb_data_t   o_rb_data;
   vita_time_t o_vita_time;

   int          errors = 0;
   int          errors_at_start = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   logic [31:0] lcg_state = 32'h63a84e7e;   // LCG seed
   sample_t     idle_word;                  // Last idle word written

   radio_core #(.TX_IDLE_RESET(IDLE_RESET)) UUT (
      .bus_clk(bus_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_rx(i_rx), .i_pps(i_pps),
      .o_tx(o_tx), .o_rb_data(o_rb_data), .o_vita_time(o_vita_time));

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_NS / 2) bus_clk = ~bus_clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: tests did not complete within %0d ns", WATCHDOG_NS);
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Returns 1 ns after the n-th rising edge
   task automatic step(input int n);
      repeat (n) @(posedge bus_clk);
      #1;
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      step(1);
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_rb(input string name, input rb_data_t got, input rb_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////
   task automatic test_reset_state();
      step(1);
      check_sample("o_tx", o_tx, IDLE_RESET);
      check_rb("o_rb_data", o_rb_data, '0);
      check_time("o_vita_time", o_vita_time, 64'd1);   // One tick since reset
   endtask

   task automatic test_test_and_idle();
      set_data_t word;
      word = next_random();
      write_setting(SR_TEST, word);
      write_setting(SR_READBACK, set_data_t'(RB_TEST));
      step(1);
      check_rb("o_rb_data", o_rb_data, {32'd0, word});
      idle_word = next_random();
      write_setting(SR_CODEC_IDLE, idle_word);
      step(1);
      check_sample("o_tx", o_tx, idle_word);
   endtask

   task automatic test_time_now();
      vita_time_t load;
      load = {next_random(), next_random()};
      write_setting(SR_TIME, load[63:32]);
      write_setting(SR_TIME + 8'd1, load[31:0]);
      write_setting(SR_TIME + 8'd2, 32'd1 << TIME_CTRL_NOW);
      check_time("o_vita_time", o_vita_time, load);
      step(7);
      check_time("o_vita_time", o_vita_time, load + 64'd7);
      write_setting(SR_READBACK, set_data_t'(RB_TIME));
      step(1);
      check_rb("o_rb_data", o_rb_data, load + 64'd8);   // Time one cycle back
      check_time("o_vita_time", o_vita_time, load + 64'd9);
   endtask

   task automatic test_pps_load();
      vita_time_t base;
      vita_time_t load;
      base = {next_random(), next_random()};
      load = {next_random(), next_random()};
      write_setting(SR_TIME, base[63:32]);
      write_setting(SR_TIME + 8'd1, base[31:0]);
      write_setting(SR_TIME + 8'd2, 32'd1 << TIME_CTRL_NOW);
      write_setting(SR_TIME, load[63:32]);
      write_setting(SR_TIME + 8'd1, load[31:0]);
      write_setting(SR_TIME + 8'd2, 32'd1 << TIME_CTRL_PPS);   // Arm, time is base + 3
      step(3);
      i_pps = 1'b1;
      step(1);
      i_pps = 1'b0;
      check_time("o_vita_time", o_vita_time, load);
      write_setting(SR_READBACK, set_data_t'(RB_TIME_PPS));
      step(1);
      check_rb("o_rb_data", o_rb_data, base + 64'd6);   // Count at the edge
      check_time("o_vita_time", o_vita_time, load + 64'd2);
   endtask

   task automatic test_codewords();
      sample_t cw0;
      sample_t cw1;
      cw0 = next_random();
      cw1 = ~cw0;
      write_setting(SR_LLR_REG0, cw0);
      write_setting(SR_LLR_REG1, cw1);
      write_setting(SR_TX_CTRL, 32'd1);
      check_sample("o_tx", o_tx, idle_word);   // Run not yet seen
      for (int i = 0; i < 4; i++) begin
         step(1);
         check_sample("o_tx", o_tx, i[0] ? cw1 : cw0);
      end
      write_setting(SR_CNTRL, 32'd1);
      check_sample("o_tx", o_tx, cw0);         // Clear not yet seen
      step(1);
      check_sample("o_tx", o_tx, cw0);         // Held at codeword 0
      write_setting(SR_CNTRL, 32'd0);
      check_sample("o_tx", o_tx, cw0);
      step(1);
      check_sample("o_tx", o_tx, cw0);         // Restart
      step(1);
      check_sample("o_tx", o_tx, cw1);
      write_setting(SR_TX_CTRL, 32'd0);
      check_sample("o_tx", o_tx, cw0);
      step(1);
      check_sample("o_tx", o_tx, idle_word);
   endtask

   task automatic test_loopback();
      sample_t rx;
      rx = next_random();
      i_rx = rx;
      write_setting(SR_READBACK, set_data_t'(RB_TXRX));
      write_setting(SR_LOOPBACK, 32'd0);
      check_rb("o_rb_data", o_rb_data, {idle_word, rx});
      write_setting(SR_LOOPBACK, 32'd1);
      step(1);
      check_rb("o_rb_data", o_rb_data, {idle_word, idle_word});
      write_setting(SR_READBACK, 32'd5);   // Unused slot
      step(1);
      check_rb("o_rb_data", o_rb_data, '0);
      step(1);
      check_rb("o_rb_data", o_rb_data, '0);   // Still zero a cycle later
   endtask

   initial begin
      i_rst_n    = 1'b0;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rx       = '0;
      i_pps      = 1'b0;
      idle_word  = IDLE_RESET;
      repeat (4) @(posedge bus_clk);
      #1 i_rst_n = 1'b1;
      test_reset_state();
      report_test("reset state");
      test_test_and_idle();
      report_test("test register and idle word");
      test_time_now();
      report_test("immediate time load");
      test_pps_load();
      report_test("PPS time load and latch");
      test_codewords();
      report_test("codeword alternation");
      test_loopback();
      report_test("loopback");
      errors += UUT.u_asserts.fail_count;
      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests_run, tests_failed, checks, errors, UUT.u_asserts.fail_count);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* build.f */
rtl/radio_pkg.sv
rtl/radio_settings.sv
rtl/time_keeper.sv
rtl/codeword_tx.sv
rtl/radio_readback.sv
rtl/radio_core.sv
testbench/radio_core_asserts.sv
testbench/radio_core_tb.sv

/* Makefile */
# Verilator build and run for the radio control core testbench

VERILATOR ?= verilator
TOP       ?= radio_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
